/* verilog/matrix_pkg.sv */
// Sizes, opcodes and error codes for the matrix calculator core.
// Compile first. RTL and testbench import it.

`default_nettype none

package matrix_pkg;

    // ======================================================================
    // Matrix geometry
    // ======================================================================
    localparam int ELEM_W    = 8;                  // One unsigned element
    localparam int MAX_DIM   = 4;                  // Rows or columns
    localparam int DIM_W     = 3;                  // Holds 0..4, 0 is empty
    localparam int MAX_ELEMS = MAX_DIM * MAX_DIM;  // Bank capacity
    localparam int ADDR_W    = 4;                  // Row-major element index

    // ======================================================================
    // Result path
    // ======================================================================
    localparam int RES_W      = 16;  // Wide enough for an 8x8 product
    localparam int FIFO_DEPTH = 4;   // Result FIFO entries, also engine credits

    // Operations on banks A and B
    typedef enum logic [1:0] {
        OP_ADD      = 2'd0,  // A + B
        OP_SUB      = 2'd1,  // A - B, wraps
        OP_SCALE    = 2'd2,  // A * scalar, B unused
        OP_HADAMARD = 2'd3   // A .* B
    } calc_op_e;

    // Reported on a single result beat
    typedef enum logic [1:0] {
        ERR_NONE  = 2'd0,
        ERR_EMPTY = 2'd1,  // Operand bank has no matrix
        ERR_DIM   = 2'd2   // A and B shapes differ
    } calc_err_e;

endpackage

`default_nettype wire

/* verilog/matrix_bank.sv */
// One matrix store: dimension registers plus a 16-entry element memory.
// Elements and dimensions are written by strobe, reads return a cycle later.

`default_nettype none

module matrix_bank (
    input  logic                         clk,
    input  logic                         rst_n,
    // Loading
    input  logic                         dim_wr,
    input  logic [matrix_pkg::DIM_W-1:0]  dim_m,
    input  logic [matrix_pkg::DIM_W-1:0]  dim_n,
    input  logic                         el_wr,
    input  logic [matrix_pkg::ADDR_W-1:0] el_addr,
    input  logic [matrix_pkg::ELEM_W-1:0] el_data,
    // Engine read port
    input  logic                         rd_en,
    input  logic [matrix_pkg::ADDR_W-1:0] rd_addr,
    output logic [matrix_pkg::ELEM_W-1:0] rd_data,
    // Current shape
    output logic [matrix_pkg::DIM_W-1:0]  m,
    output logic [matrix_pkg::DIM_W-1:0]  n
);

    import matrix_pkg::*;

    logic [ELEM_W-1:0] mem [MAX_ELEMS];  // Row-major elements

    // ======================================================================
    // Dimensions
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m <= '0;  // Empty after reset
            n <= '0;
        end else if (dim_wr) begin
            m <= dim_m;
            n <= dim_n;
        end
    end

    // ======================================================================
    // Element storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (el_wr) begin
            mem[el_addr] <= el_data;
        end
    end

    // Registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // Shapes larger than 4x4 would index past the memory
    a_dim_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        dim_wr |-> (dim_m <= DIM_W'(MAX_DIM)) && (dim_n <= DIM_W'(MAX_DIM))
    ) else $error("dimension write above MAX_DIM");

endmodule

`default_nettype wire

/* verilog/result_fifo.sv */
// First-word fall-through FIFO for result beats (data, last flag, error).
// Output side is a valid/ready pair, pop tells the engine a beat has left.

`default_nettype none

module result_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        push,
    input  logic [matrix_pkg::RES_W-1:0] push_data,
    input  logic                        push_last,
    input  matrix_pkg::calc_err_e       push_err,
    input  logic                        res_ready,
    output logic                        pop,
    output logic                        res_valid,
    output logic [matrix_pkg::RES_W-1:0] res_data,
    output logic                        res_last,
    output matrix_pkg::calc_err_e       res_err
);

    import matrix_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [RES_W-1:0] data_mem [DEPTH];
    logic             last_mem [DEPTH];
    calc_err_e        err_mem  [DEPTH];

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;

    // Wrap for non power of two depths too
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign res_valid = (count != '0);
    assign pop       = res_valid && res_ready;
    assign res_data  = data_mem[rd_ptr];  // Head shows without a read strobe
    assign res_last  = last_mem[rd_ptr];
    assign res_err   = err_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)  rd_ptr <= ptr_inc(rd_ptr);
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= push_data;
            last_mem[wr_ptr] <= push_last;
            err_mem[wr_ptr]  <= push_err;
        end
    end

    // Engine credits must keep us from overflowing
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> (count < CNT_W'(DEPTH))
    ) else $error("push into full result FIFO");

    a_stall_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> res_valid && $stable(res_data)
    ) else $error("result data changed while stalled");

endmodule

`default_nettype wire

/* verilog/calc_engine.sv */
// Command checker and element sequencer for the two matrix banks.
// Accepts one command at a time, reads A and B in step and pushes one
// result beat per element into the result FIFO under a credit limit.

`default_nettype none

module calc_engine (
    input  logic                          clk,
    input  logic                          rst_n,
    // Command side
    input  logic                          cmd_valid,
    input  matrix_pkg::calc_op_e          cmd_op,
    input  logic [matrix_pkg::ELEM_W-1:0] cmd_scalar,
    output logic                          cmd_ready,
    // Bank side
    input  logic [matrix_pkg::DIM_W-1:0]  a_m,
    input  logic [matrix_pkg::DIM_W-1:0]  a_n,
    input  logic [matrix_pkg::DIM_W-1:0]  b_m,
    input  logic [matrix_pkg::DIM_W-1:0]  b_n,
    input  logic [matrix_pkg::ELEM_W-1:0] a_data,
    input  logic [matrix_pkg::ELEM_W-1:0] b_data,
    output logic                          rd_en,
    output logic [matrix_pkg::ADDR_W-1:0] rd_addr,
    // FIFO side
    input  logic                          pop,
    output logic                          push,
    output logic [matrix_pkg::RES_W-1:0]  push_data,
    output logic                          push_last,
    output matrix_pkg::calc_err_e         push_err
);

    import matrix_pkg::*;

    localparam int CNT_W  = ADDR_W + 1;               // Counts up to 16
    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_RUN
    } state_e;

    state_e            state_q;
    calc_op_e          op_q;
    logic [ELEM_W-1:0] scalar_q;
    calc_err_e         err_q;
    calc_err_e         chk_err;
    logic [CNT_W-1:0]  total_q;    // Beats for this command
    logic [CNT_W-1:0]  idx_q;      // Next index to read
    logic [CNT_W-1:0]  a_elems;
    logic [CRED_W-1:0] credit_q;   // FIFO entries plus reads in flight
    logic              issue;
    logic              vld_q;      // Bank data valid this cycle
    logic              last_q;
    logic [RES_W-1:0]  a_ext, b_ext, s_ext, result;

    assign cmd_ready = (state_q == ST_IDLE);

    // ======================================================================
    // Command check
    // ======================================================================
    assign a_elems = CNT_W'(a_m) * CNT_W'(a_n);

    always_comb begin
        chk_err = ERR_NONE;
        if (a_m == '0 || a_n == '0) begin
            chk_err = ERR_EMPTY;
        end else if (op_q != OP_SCALE) begin
            if (b_m == '0 || b_n == '0) begin
                chk_err = ERR_EMPTY;
            end else if (a_m != b_m || a_n != b_n) begin
                chk_err = ERR_DIM;
            end
        end
    end

    // ======================================================================
    // Read sequencing
    // ======================================================================
    // An error command still takes one slot, so its beat obeys credits too
    assign issue   = (state_q == ST_RUN) && (idx_q != total_q) &&
                     (credit_q < CRED_W'(FIFO_DEPTH));
    assign rd_en   = issue;
    assign rd_addr = idx_q[ADDR_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ST_IDLE;
            idx_q    <= '0;
            credit_q <= '0;
            vld_q    <= 1'b0;
            last_q   <= 1'b0;
        end else begin
            vld_q    <= issue;
            last_q   <= issue && (idx_q == total_q - CNT_W'(1));
            credit_q <= credit_q + CRED_W'(issue) - CRED_W'(pop);
            if (issue) idx_q <= idx_q + CNT_W'(1);

            case (state_q)
                ST_IDLE: begin
                    if (cmd_valid) state_q <= ST_CHECK;
                end
                ST_CHECK: begin
                    idx_q   <= '0;
                    state_q <= ST_RUN;
                end
                ST_RUN: begin
                    if (push && push_last) state_q <= ST_IDLE;  // Final beat out
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command fields and check outcome
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            op_q     <= cmd_op;
            scalar_q <= cmd_scalar;
        end
        if (state_q == ST_CHECK) begin
            err_q   <= chk_err;
            total_q <= (chk_err != ERR_NONE) ? CNT_W'(1) : a_elems;
        end
    end

    // ======================================================================
    // Element arithmetic
    // ======================================================================
    assign a_ext = RES_W'(a_data);
    assign b_ext = RES_W'(b_data);
    assign s_ext = RES_W'(scalar_q);

    always_comb begin
        case (op_q)
            OP_ADD:   result = a_ext + b_ext;
            OP_SUB:   result = a_ext - b_ext;  // Two's complement wrap
            OP_SCALE: result = a_ext * s_ext;
            default:  result = a_ext * b_ext;  // Hadamard
        endcase
    end

    assign push      = vld_q;
    assign push_last = last_q;
    assign push_err  = err_q;
    assign push_data = (err_q != ERR_NONE) ? '0 : result;

    a_credit_limit: assert property (
        @(posedge clk) disable iff (!rst_n) credit_q <= CRED_W'(FIFO_DEPTH)
    ) else $error("engine credits above FIFO depth");

endmodule

`default_nettype wire

/* verilog/matrix_calc_top.sv */
// Matrix calculator core: banks A and B, the compute engine and the
// result FIFO. Load through the write strobes while cmd_ready is high.

`default_nettype none

module matrix_calc_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // Loading
    input  logic                          a_dim_wr,
    input  logic                          b_dim_wr,
    input  logic [matrix_pkg::DIM_W-1:0]  dim_m,
    input  logic [matrix_pkg::DIM_W-1:0]  dim_n,
    input  logic                          a_el_wr,
    input  logic                          b_el_wr,
    input  logic [matrix_pkg::ADDR_W-1:0] el_addr,
    input  logic [matrix_pkg::ELEM_W-1:0] el_data,
    // Commands
    input  logic                          cmd_valid,
    input  matrix_pkg::calc_op_e          cmd_op,
    input  logic [matrix_pkg::ELEM_W-1:0] cmd_scalar,
    output logic                          cmd_ready,
    // Results
    input  logic                          res_ready,
    output logic                          res_valid,
    output logic [matrix_pkg::RES_W-1:0]  res_data,
    output logic                          res_last,
    output matrix_pkg::calc_err_e         res_err
);

    import matrix_pkg::*;

    logic [DIM_W-1:0]  a_m, a_n, b_m, b_n;
    logic [ELEM_W-1:0] a_rd_data, b_rd_data;
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic              push, push_last, pop;
    logic [RES_W-1:0]  push_data;
    calc_err_e         push_err;

    // ======================================================================
    // Operand banks, read in step
    // ======================================================================
    matrix_bank bank_a (
        .clk(clk), .rst_n(rst_n),
        .dim_wr(a_dim_wr), .dim_m(dim_m), .dim_n(dim_n),
        .el_wr(a_el_wr), .el_addr(el_addr), .el_data(el_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(a_rd_data),
        .m(a_m), .n(a_n)
    );

    matrix_bank bank_b (
        .clk(clk), .rst_n(rst_n),
        .dim_wr(b_dim_wr), .dim_m(dim_m), .dim_n(dim_n),
        .el_wr(b_el_wr), .el_addr(el_addr), .el_data(el_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(b_rd_data),
        .m(b_m), .n(b_n)
    );

    calc_engine engine (
        .clk(clk), .rst_n(rst_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_scalar(cmd_scalar),
        .cmd_ready(cmd_ready),
        .a_m(a_m), .a_n(a_n), .b_m(b_m), .b_n(b_n),
        .a_data(a_rd_data), .b_data(b_rd_data),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .pop(pop), .push(push), .push_data(push_data),
        .push_last(push_last), .push_err(push_err)
    );

    // Output buffer, depth matches engine credits
    result_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) res_fifo (
        .clk(clk), .rst_n(rst_n),
        .push(push), .push_data(push_data),
        .push_last(push_last), .push_err(push_err),
        .res_ready(res_ready), .pop(pop),
        .res_valid(res_valid), .res_data(res_data),
        .res_last(res_last), .res_err(res_err)
    );

endmodule

`default_nettype wire

/* verif/tb_matrix_model.svh */
// Testbench model of the matrix calculator, included inside the testbench top.
// Holds shadow copies of banks A and B and builds the expected result beats.
`ifndef TB_MATRIX_MODEL_SVH
`define TB_MATRIX_MODEL_SVH

// One expected result beat
typedef struct packed {
    calc_err_e        err;
    logic             last;
    logic [RES_W-1:0] data;
} beat_t;

// ======================================================================
// Shadow banks
// ======================================================================
logic [ELEM_W-1:0] shadow_a [MAX_ELEMS];
logic [ELEM_W-1:0] shadow_b [MAX_ELEMS];
int a_rows = 0;  // Empty after reset
int a_cols = 0;
int b_rows = 0;
int b_cols = 0;

beat_t exp_q [$];        // Beats still to arrive, oldest first
int    beats_expected = 0;

// Expected value of element k, computed in plain integers
function automatic logic [RES_W-1:0] ref_element(input calc_op_e op,
                                                 input logic [ELEM_W-1:0] scalar,
                                                 input int k);
    int av;
    int bv;
    av = int'(shadow_a[ADDR_W'(k)]);
    bv = int'(shadow_b[ADDR_W'(k)]);
    case (op)
        OP_ADD:   return RES_W'(av + bv);
        OP_SUB:   return RES_W'(av - bv);  // Negative values wrap mod 2^16
        OP_SCALE: return RES_W'(av * int'(scalar));
        default:  return RES_W'(av * bv);
    endcase
endfunction

// Empty bank first, then shape mismatch
function automatic calc_err_e expected_error(input calc_op_e op);
    if (a_rows == 0 || a_cols == 0) return ERR_EMPTY;
    if (op == OP_SCALE) return ERR_NONE;  // B not used
    if (b_rows == 0 || b_cols == 0) return ERR_EMPTY;
    if (a_rows != b_rows || a_cols != b_cols) return ERR_DIM;
    return ERR_NONE;
endfunction

// Queue every beat one command should return
function automatic void expect_command(input calc_op_e op,
                                       input logic [ELEM_W-1:0] scalar);
    calc_err_e err;
    beat_t     b;
    int        count;
    err = expected_error(op);
    if (err != ERR_NONE) begin
        b.err  = err;
        b.last = 1'b1;
        b.data = '0;
        exp_q.push_back(b);
        beats_expected++;
    end else begin
        count = a_rows * a_cols;  // Result has A's shape
        for (int k = 0; k < count; k++) begin
            b.err  = ERR_NONE;
            b.last = (k == count - 1);
            b.data = ref_element(op, scalar, k);
            exp_q.push_back(b);
            beats_expected++;
        end
    end
endfunction

`endif

/* verif/tb_matrix_calc.sv */
// Testbench for the matrix calculator core. Loads random matrices, issues
// commands and checks every result beat against the shadow model.
// Run through run_sim.sh, which compiles filelist.f with Verilator.

`default_nettype none

module tb_matrix_calc;

    import matrix_pkg::*;

    localparam int NUM_TESTS   = 5;
    localparam int TOTAL_BEATS = 80;  // 1 + 24 + 7 + 16 + 32
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS + 20 * TOTAL_BEATS;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              a_dim_wr, b_dim_wr, a_el_wr, b_el_wr;
    logic [DIM_W-1:0]  dim_m, dim_n;
    logic [ADDR_W-1:0] el_addr;
    logic [ELEM_W-1:0] el_data;
    logic              cmd_valid;
    calc_op_e          cmd_op;
    logic [ELEM_W-1:0] cmd_scalar;
    logic              cmd_ready;
    logic              res_ready = 1'b0;  // Owned by the compare process
    logic              res_valid, res_last;
    logic [RES_W-1:0]  res_data;
    calc_err_e         res_err;

    `include "tb_matrix_model.svh"

    int    value_errors = 0;  // Wrong data, last or error code
    int    beat_errors  = 0;  // Extra beats
    int    check_errors = 0;  // Idle state after reset and at the end
    int    cycles       = 0;
    int    beats_seen   = 0;
    bit    random_ready = 1'b0;
    beat_t head;

    matrix_calc_top uut (
        .clk(clk), .rst_n(rst_n),
        .a_dim_wr(a_dim_wr), .b_dim_wr(b_dim_wr), .dim_m(dim_m), .dim_n(dim_n),
        .a_el_wr(a_el_wr), .b_el_wr(b_el_wr), .el_addr(el_addr), .el_data(el_data),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_scalar(cmd_scalar),
        .cmd_ready(cmd_ready),
        .res_ready(res_ready), .res_valid(res_valid), .res_data(res_data),
        .res_last(res_last), .res_err(res_err)
    );

    always #4 clk = ~clk;

    task automatic print_counts();
        $display("Errors: %0d value, %0d beat, %0d check; %0d of %0d beats checked",
                 value_errors, beat_errors, check_errors, beats_seen, beats_expected);
    endtask

    // ======================================================================
    // Timeout
    // ======================================================================
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish in %0d cycles, %0d beats never arrived",
                     CYCLE_LIMIT, exp_q.size());
            print_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ======================================================================
    // Result sink and compare
    // ======================================================================
    // res_ready set first, so the sampled pair is what the next edge sees
    always @(negedge clk) begin
        res_ready = random_ready ? 1'($urandom) : 1'b1;
        if (rst_n && res_valid && res_ready) begin
            if (exp_q.size() == 0) begin
                beat_errors++;
                $display("ERROR at %0t: extra result beat %h arrived with none expected",
                         $time, res_data);
            end else begin
                head = exp_q.pop_front();
                assert (res_data == head.data) else begin
                    value_errors++;
                    $display("FAILED %0t: beat %0d data %h, expected %h",
                             $time, beats_seen, res_data, head.data);
                end
                assert (res_last == head.last) else begin
                    value_errors++;
                    $display("FAILED %0t: beat %0d last %b, expected %b",
                             $time, beats_seen, res_last, head.last);
                end
                assert (res_err == head.err) else begin
                    value_errors++;
                    $display("FAILED %0t: beat %0d error code %0d, expected %0d",
                             $time, beats_seen, res_err, head.err);
                end
                beats_seen++;
            end
        end
    end

    // ======================================================================
    // Stimulus tasks
    // ======================================================================
    // Dimensions first and then random elements in row-major order
    task automatic load_matrix(input bit to_b, input int rows, input int cols);
        logic [ELEM_W-1:0] value;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        dim_m = DIM_W'(rows);
        dim_n = DIM_W'(cols);
        if (to_b) b_dim_wr = 1'b1;
        else      a_dim_wr = 1'b1;
        @(negedge clk);
        a_dim_wr = 1'b0;
        b_dim_wr = 1'b0;
        for (int k = 0; k < rows * cols; k++) begin
            value   = ELEM_W'($urandom);
            el_addr = ADDR_W'(k);
            el_data = value;
            if (to_b) begin
                b_el_wr = 1'b1;
                shadow_b[ADDR_W'(k)] = value;
            end else begin
                a_el_wr = 1'b1;
                shadow_a[ADDR_W'(k)] = value;
            end
            @(negedge clk);
        end
        a_el_wr = 1'b0;
        b_el_wr = 1'b0;
        if (to_b) begin
            b_rows = rows;
            b_cols = cols;
        end else begin
            a_rows = rows;
            a_cols = cols;
        end
    endtask

    // Accepted on the edge after a falling edge that sees cmd_ready high
    task automatic send_cmd(input calc_op_e op, input logic [ELEM_W-1:0] scalar);
        expect_command(op, scalar);
        @(negedge clk);
        cmd_valid  = 1'b1;
        cmd_op     = op;
        cmd_scalar = scalar;
        while (!cmd_ready) @(negedge clk);
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        rst_n      = 1'b0;
        a_dim_wr   = 1'b0;
        b_dim_wr   = 1'b0;
        a_el_wr    = 1'b0;
        b_el_wr    = 1'b0;
        dim_m      = '0;
        dim_n      = '0;
        el_addr    = '0;
        el_data    = '0;
        cmd_valid  = 1'b0;
        cmd_op     = OP_ADD;
        cmd_scalar = '0;
        void'($urandom(21511));
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (cmd_ready === 1'b1 && res_valid === 1'b0) else begin
            check_errors++;
            $display("FAILED %0t: after reset cmd_ready %b res_valid %b",
                     $time, cmd_ready, res_valid);
        end

        // Test 1 on empty banks
        send_cmd(OP_ADD, 8'd0);
        wait_results();

        // Test 2 adds and subtracts 3x4 matrices
        load_matrix(1'b0, 3, 4);
        load_matrix(1'b1, 3, 4);
        send_cmd(OP_ADD, 8'd0);
        send_cmd(OP_SUB, 8'd0);
        wait_results();

        // Test 3 scales A alone and then hits a shape mismatch
        load_matrix(1'b0, 2, 3);
        load_matrix(1'b1, 4, 4);
        send_cmd(OP_SCALE, ELEM_W'($urandom));
        send_cmd(OP_HADAMARD, 8'd0);
        wait_results();

        // Test 4 runs a 4x4 Hadamard under random back-pressure
        load_matrix(1'b0, 4, 4);
        load_matrix(1'b1, 4, 4);
        random_ready = 1'b1;
        send_cmd(OP_HADAMARD, 8'd0);
        wait_results();

        // Test 5 loads new contents for back-to-back commands
        load_matrix(1'b0, 2, 4);
        load_matrix(1'b1, 2, 4);
        send_cmd(OP_ADD, 8'd0);
        send_cmd(OP_HADAMARD, 8'd0);
        send_cmd(OP_SUB, 8'd0);
        send_cmd(OP_SCALE, ELEM_W'($urandom));
        wait_results();

        random_ready = 1'b0;
        repeat (10) @(negedge clk);  // Give stray beats a chance to show
        assert (cmd_ready === 1'b1 && res_valid === 1'b0) else begin
            check_errors++;
            $display("FAILED %0t: engine not idle at the end, cmd_ready %b res_valid %b",
                     $time, cmd_ready, res_valid);
        end
        print_counts();
        if (value_errors == 0 && beat_errors == 0 && check_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verif
verilog/matrix_pkg.sv
verilog/matrix_bank.sv
verilog/result_fifo.sv
verilog/calc_engine.sv
verilog/matrix_calc_top.sv
verif/tb_matrix_calc.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# Exit status is 0 only when the pass line appears in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_matrix_calc \
    -Mdir obj_dir \
    -f filelist.f

# A failing assertion may stop the model early, keep its output anyway
out=$(./obj_dir/Vtb_matrix_calc 2>&1) || true
echo "$out"

if echo "$out" | grep -qxF "PASS: all tests"; then
    exit 0
else
    exit 1
fi
